/* Bender.yml */
package:
  name: video_gen

sources:
  - design/video_pkg.sv
  - design/video_timing.sv
  - design/video_regs.sv
  - design/video_playfield.sv
  - design/video_gen.sv
  - target: test
    files:
      - testbench/video_gen_tb.sv

/* design/video_gen.sv */
`timescale 1ns/1ps

module video_gen (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           xr_wr_i,
    input  logic [video_pkg::XR_NUM_W-1:0] xr_num_i,
    input  video_pkg::word_t               xr_data_i,
    output video_pkg::word_t               xr_data_o,
    output video_pkg::vram_req_t           vram_o,
    input  video_pkg::word_t               vram_data_i,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           dv_de_o,
    output logic                           h_blank_o,
    output logic                           v_blank_o,
    output video_pkg::color_t              color_index_o,
    output logic                           video_intr_o
);
    import video_pkg::*;

    vid_sync_t sync;
    hres_t     h_count;
    vres_t     v_count;
    logic      end_of_line;
    logic      end_of_frame;
    logic      end_of_visible;
    pf_cfg_t   pf_cfg;

    assign hsync_o   = sync.hsync;
    assign vsync_o   = sync.vsync;
    assign dv_de_o   = sync.dv_de;
    assign h_blank_o = ~sync.h_visible;
    assign v_blank_o = ~sync.v_visible;

    video_timing i_video_timing (
        .clk              (clk),
        .reset_i          (reset_i),
        .sync_o           (sync),
        .h_count_o        (h_count),
        .v_count_o        (v_count),
        .end_of_line_o    (end_of_line),
        .end_of_frame_o   (end_of_frame),
        .end_of_visible_o (end_of_visible)
    );

    video_regs i_video_regs (
        .clk              (clk),
        .reset_i          (reset_i),
        .xr_wr_i          (xr_wr_i),
        .xr_num_i         (xr_num_i),
        .xr_data_i        (xr_data_i),
        .xr_data_o        (xr_data_o),
        .v_count_i        (v_count),
        .end_of_visible_i (end_of_visible),
        .cfg_o            (pf_cfg),
        .video_intr_o     (video_intr_o)
    );

    video_playfield i_video_playfield (
        .clk            (clk),
        .reset_i        (reset_i),
        .cfg_i          (pf_cfg),
        .h_count_i      (h_count),
        .v_visible_i    (sync.v_visible),
        .end_of_line_i  (end_of_line),
        .end_of_frame_i (end_of_frame),
        .vram_o         (vram_o),
        .vram_data_i    (vram_data_i),
        .color_index_o  (color_index_o)
    );

endmodule

/* design/video_pkg.sv */
package video_pkg;

    // reduced test raster, visible columns sit after the offscreen ones
    localparam int VISIBLE_WIDTH   = 32;
    localparam int H_FRONT_PORCH   = 4;
    localparam int H_SYNC_PULSE    = 4;
    localparam int H_BACK_PORCH    = 8;
    localparam int OFFSCREEN_WIDTH = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int TOTAL_WIDTH     = VISIBLE_WIDTH + OFFSCREEN_WIDTH;

    localparam int VISIBLE_HEIGHT  = 8;
    localparam int V_FRONT_PORCH   = 1;
    localparam int V_SYNC_PULSE    = 1;
    localparam int V_BACK_PORCH    = 2;
    localparam int TOTAL_HEIGHT    = VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    localparam int H_FETCH_BEGIN   = OFFSCREEN_WIDTH - 4;     // prefetch ahead of first pixel

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 16;
    localparam int COLOR_W   = 8;
    localparam int XR_NUM_W  = 5;
    localparam int H_COUNT_W = $clog2(TOTAL_WIDTH);
    localparam int V_COUNT_W = $clog2(TOTAL_HEIGHT);

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [COLOR_W-1:0]   color_t;
    typedef logic [H_COUNT_W-1:0] hres_t;
    typedef logic [V_COUNT_W-1:0] vres_t;

    // xr register numbers
    localparam logic [XR_NUM_W-1:0] XR_VID_CTRL     = 5'h00;
    localparam logic [XR_NUM_W-1:0] XR_SCANLINE     = 5'h01;   // read only
    localparam logic [XR_NUM_W-1:0] XR_VID_LEFT     = 5'h02;
    localparam logic [XR_NUM_W-1:0] XR_VID_RIGHT    = 5'h03;
    localparam logic [XR_NUM_W-1:0] XR_PA_GFX_CTRL  = 5'h04;
    localparam logic [XR_NUM_W-1:0] XR_PA_DISP_ADDR = 5'h05;
    localparam logic [XR_NUM_W-1:0] XR_PA_LINE_LEN  = 5'h06;

    localparam color_t RESET_BORDER   = 8'h08;               // dark grey
    localparam word_t  RESET_LINE_LEN = WORD_W'(VISIBLE_WIDTH / 2);

    typedef struct packed {
        logic [7:0] reserved;
        color_t     border_color;
    } vid_ctrl_t;

    typedef struct packed {
        color_t     colorbase;
        logic       blank;
        logic [6:0] reserved;
    } gfx_ctrl_t;

    // one data word, meaning depends on register number
    typedef union packed {
        word_t     raw;
        vid_ctrl_t vid_ctrl;
        gfx_ctrl_t gfx_ctrl;
    } xr_word_u;

    typedef struct packed {
        color_t border_color;
        hres_t  vid_left;
        hres_t  vid_right;
        color_t colorbase;
        logic   blank;
        addr_t  start_addr;
        word_t  line_len;
    } pf_cfg_t;

    typedef struct packed {
        logic  sel;
        addr_t addr;
    } vram_req_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic h_visible;
        logic v_visible;
        logic dv_de;
    } vid_sync_t;

endpackage

/* design/video_playfield.sv */
`timescale 1ns/1ps

module video_playfield (
    input  logic                  clk,
    input  logic                  reset_i,
    input  video_pkg::pf_cfg_t    cfg_i,
    input  video_pkg::hres_t      h_count_i,
    input  logic                  v_visible_i,
    input  logic                  end_of_line_i,
    input  logic                  end_of_frame_i,
    output video_pkg::vram_req_t  vram_o,
    input  video_pkg::word_t      vram_data_i,
    output video_pkg::color_t     color_index_o
);
    import video_pkg::*;

    addr_t  line_addr;                              // first word of current line
    addr_t  fetch_addr;                             // next word to read
    hres_t  fetch_off;
    hres_t  pix_x;
    logic   fetch_now;
    logic   rd_valid;                               // vram data present this cycle
    logic   in_window;
    word_t  pix_shift;
    color_t next_color;

    // word k: sel at H_FETCH_BEGIN+1+2k, data one later, pixels 2k/2k+1 from OFFSCREEN_WIDTH+2k
    always_comb begin
        fetch_off = h_count_i - hres_t'(H_FETCH_BEGIN);      // wraps high before the window
        fetch_now = v_visible_i && !cfg_i.blank &&
                    (fetch_off < hres_t'(VISIBLE_WIDTH)) && !fetch_off[0];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_o     <= '0;
            rd_valid   <= 1'b0;
            line_addr  <= '0;
            fetch_addr <= '0;
        end else begin
            vram_o.sel <= fetch_now;
            rd_valid   <= vram_o.sel;
            if (fetch_now) begin
                vram_o.addr <= fetch_addr;
                fetch_addr  <= fetch_addr + 1'b1;
            end
            if (end_of_frame_i) begin
                line_addr  <= cfg_i.start_addr;
                fetch_addr <= cfg_i.start_addr;
            end else if (end_of_line_i) begin
                line_addr  <= line_addr + cfg_i.line_len;
                fetch_addr <= line_addr + cfg_i.line_len;
            end
        end
    end

    // load on returned word, otherwise move low byte up
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            pix_shift <= vram_data_i;
        end else begin
            pix_shift <= pix_shift << COLOR_W;
        end
    end

    // pixel shown next cycle, so column is h_count + 1
    always_comb begin
        pix_x      = h_count_i - hres_t'(OFFSCREEN_WIDTH - 1);
        in_window  = v_visible_i && !cfg_i.blank &&
                     (pix_x >= cfg_i.vid_left) && (pix_x < cfg_i.vid_right);
        next_color = cfg_i.border_color;
        if (in_window) begin
            next_color = pix_shift[WORD_W-1 -: COLOR_W] ^ cfg_i.colorbase;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
        end else begin
            color_index_o <= next_color;
        end
    end

endmodule

/* design/video_regs.sv */
`timescale 1ns/1ps

module video_regs (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         xr_wr_i,
    input  logic [video_pkg::XR_NUM_W-1:0] xr_num_i,
    input  video_pkg::word_t             xr_data_i,
    output video_pkg::word_t             xr_data_o,
    input  video_pkg::vres_t             v_count_i,
    input  logic                         end_of_visible_i,
    output video_pkg::pf_cfg_t           cfg_o,
    output logic                         video_intr_o
);
    import video_pkg::*;

    xr_word_u wr_word;
    xr_word_u rd_word;

    assign wr_word.raw = xr_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o <= '{
                border_color: RESET_BORDER,
                vid_left:     '0,
                vid_right:    hres_t'(VISIBLE_WIDTH),
                colorbase:    '0,
                blank:        1'b1,                 // playfield starts blanked
                start_addr:   '0,
                line_len:     RESET_LINE_LEN
            };
            video_intr_o <= 1'b0;
        end else begin
            video_intr_o <= end_of_visible_i;       // one pulse per frame
            if (xr_wr_i) begin
                case (xr_num_i)
                    XR_VID_CTRL: begin
                        cfg_o.border_color <= wr_word.vid_ctrl.border_color;
                    end
                    XR_VID_LEFT: begin
                        cfg_o.vid_left <= hres_t'(wr_word.raw);
                    end
                    XR_VID_RIGHT: begin
                        cfg_o.vid_right <= hres_t'(wr_word.raw);
                    end
                    XR_PA_GFX_CTRL: begin
                        cfg_o.colorbase <= wr_word.gfx_ctrl.colorbase;
                        cfg_o.blank     <= wr_word.gfx_ctrl.blank;
                    end
                    XR_PA_DISP_ADDR: begin
                        cfg_o.start_addr <= wr_word.raw;
                    end
                    XR_PA_LINE_LEN: begin
                        cfg_o.line_len <= wr_word.raw;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        rd_word.raw = '0;                           // reserved and unused read zero
        case (xr_num_i)
            XR_VID_CTRL: begin
                rd_word.vid_ctrl.border_color = cfg_o.border_color;
            end
            XR_SCANLINE:     rd_word.raw = WORD_W'(v_count_i);
            XR_VID_LEFT:     rd_word.raw = WORD_W'(cfg_o.vid_left);
            XR_VID_RIGHT:    rd_word.raw = WORD_W'(cfg_o.vid_right);
            XR_PA_GFX_CTRL: begin
                rd_word.gfx_ctrl.colorbase = cfg_o.colorbase;
                rd_word.gfx_ctrl.blank     = cfg_o.blank;
            end
            XR_PA_DISP_ADDR: rd_word.raw = cfg_o.start_addr;
            XR_PA_LINE_LEN:  rd_word.raw = cfg_o.line_len;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_data_o <= '0;
        end else begin
            xr_data_o <= rd_word.raw;               // valid one cycle after number
        end
    end

    a_left_in_range: assert property (
        @(posedge clk) disable iff (reset_i)
        (xr_wr_i && (xr_num_i == XR_VID_LEFT)) |=> (cfg_o.vid_left <= hres_t'(VISIBLE_WIDTH))
    ) else $error("vid_left beyond visible width");

endmodule

/* design/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
    input  logic                  clk,
    input  logic                  reset_i,
    output video_pkg::vid_sync_t  sync_o,
    output video_pkg::hres_t      h_count_o,
    output video_pkg::vres_t      v_count_o,
    output logic                  end_of_line_o,
    output logic                  end_of_frame_o,
    output logic                  end_of_visible_o
);
    import video_pkg::*;

    hres_t h_count;
    vres_t v_count;
    hres_t h_next;
    vres_t v_next;
    logic  h_vis_next;
    logic  v_vis_next;

    assign h_count_o = h_count;
    assign v_count_o = v_count;

    assign end_of_line_o    = (h_count == hres_t'(TOTAL_WIDTH - 1));
    assign end_of_frame_o   = end_of_line_o && (v_count == vres_t'(TOTAL_HEIGHT - 1));
    assign end_of_visible_o = end_of_line_o && (v_count == vres_t'(VISIBLE_HEIGHT - 1));

    always_comb begin
        h_next = end_of_line_o ? '0 : h_count + 1'b1;
        v_next = v_count;
        if (end_of_line_o) begin
            v_next = end_of_frame_o ? '0 : v_count + 1'b1;
        end
        h_vis_next = (h_next >= hres_t'(OFFSCREEN_WIDTH));     // visible part is the line tail
        v_vis_next = (v_next < vres_t'(VISIBLE_HEIGHT));
    end

    // flags are derived from next counts so they line up with the counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
            sync_o  <= '0;
        end else begin
            h_count          <= h_next;
            v_count          <= v_next;
            sync_o.hsync     <= (h_next >= hres_t'(H_FRONT_PORCH)) &&
                                (h_next < hres_t'(H_FRONT_PORCH + H_SYNC_PULSE));
            sync_o.vsync     <= (v_next == vres_t'(VISIBLE_HEIGHT + V_FRONT_PORCH));
            sync_o.h_visible <= h_vis_next;
            sync_o.v_visible <= v_vis_next;
            sync_o.dv_de     <= h_vis_next && v_vis_next;
        end
    end

    a_count_range: assert property (
        @(posedge clk) disable iff (reset_i)
        (h_count < hres_t'(TOTAL_WIDTH)) && (v_count < vres_t'(TOTAL_HEIGHT))
    ) else $error("video counter out of range");

    a_de_visible: assert property (
        @(posedge clk) disable iff (reset_i)
        sync_o.dv_de |-> (h_count >= hres_t'(OFFSCREEN_WIDTH)) &&
                         (v_count < vres_t'(VISIBLE_HEIGHT))
    ) else $error("dv_de outside visible area");

endmodule

/* testbench/video_gen_tb.sv */
`timescale 1ns/1ps

module video_gen_tb;
    import video_pkg::*;

    logic                clk;
    logic                reset_i;
    logic                xr_wr_i;
    logic [XR_NUM_W-1:0] xr_num_i;
    word_t               xr_data_i;
    word_t               xr_data_o;
    vram_req_t           vram_o;
    word_t               vram_data_i;
    logic                hsync_o;
    logic                vsync_o;
    logic                dv_de_o;
    logic                h_blank_o;
    logic                v_blank_o;
    color_t              color_index_o;
    logic                video_intr_o;

    logic [31:0] rng;
    int          mismatch_count;
    int          timeout_count;
    int          checked_count;
    int          pix_n;                             // pixel number within frame
    logic        check_en;
    pf_cfg_t     exp_cfg;

    video_gen i_video_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .xr_wr_i       (xr_wr_i),
        .xr_num_i      (xr_num_i),
        .xr_data_i     (xr_data_i),
        .xr_data_o     (xr_data_o),
        .vram_o        (vram_o),
        .vram_data_i   (vram_data_i),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o),
        .h_blank_o     (h_blank_o),
        .v_blank_o     (v_blank_o),
        .color_index_o (color_index_o),
        .video_intr_o  (video_intr_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // video RAM contents, a mix of the whole address
    function automatic word_t vram_word(addr_t addr);
        logic [31:0] v;
        v = xorshift32({addr ^ 16'h5a3c, addr} ^ 32'h9e3779b9);
        return v[31:16] ^ v[15:0];
    endfunction

    function automatic color_t ref_pixel(int x, int y, pf_cfg_t cfg);
        addr_t  addr;
        word_t  data;
        color_t pix;
        if (cfg.blank || (x < int'(cfg.vid_left)) || (x >= int'(cfg.vid_right))) begin
            return cfg.border_color;
        end
        addr = addr_t'(cfg.start_addr + y * cfg.line_len + x / 2);   // one word per pixel pair
        data = vram_word(addr);
        pix  = (x % 2 == 0) ? data[15:8] : data[7:0];                // high byte first
        return pix ^ cfg.colorbase;
    endfunction

    // reserved bits read zero
    function automatic word_t readback_of(logic [XR_NUM_W-1:0] num, word_t value);
        case (num)
            XR_VID_CTRL:    return value & 16'h00ff;
            XR_PA_GFX_CTRL: return value & 16'hff80;
            default:        return value;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic write_reg(input logic [XR_NUM_W-1:0] num, input word_t value);
        @(posedge clk);
        xr_wr_i   <= 1'b1;
        xr_num_i  <= num;
        xr_data_i <= value;
        @(posedge clk);
        xr_wr_i   <= 1'b0;
    endtask

    task automatic read_reg(input logic [XR_NUM_W-1:0] num, output word_t value);
        @(posedge clk);
        xr_num_i <= num;
        @(posedge clk);                             // readback registered here
        @(posedge clk);
        value = xr_data_o;
    endtask

    task automatic set_config(input pf_cfg_t cfg);
        write_reg(XR_VID_CTRL, {8'h00, cfg.border_color});
        write_reg(XR_VID_LEFT, word_t'(cfg.vid_left));
        write_reg(XR_VID_RIGHT, word_t'(cfg.vid_right));
        write_reg(XR_PA_GFX_CTRL, {cfg.colorbase, cfg.blank, 7'b0});
        write_reg(XR_PA_DISP_ADDR, cfg.start_addr);
        write_reg(XR_PA_LINE_LEN, cfg.line_len);
        exp_cfg = cfg;
    endtask

    task automatic wait_vsync_rise();
        int   n;
        logic prev;
        logic found;
        prev  = vsync_o;
        found = 1'b0;
        for (n = 0; (n < 2 * TOTAL_WIDTH * TOTAL_HEIGHT) && !found; n++) begin
            @(posedge clk);
            if (vsync_o && !prev) begin
                found = 1'b1;
            end
            prev = vsync_o;
        end
        if (!found) begin
            $display("Timeout at %0t: no vsync pulse within two frames", $time);
            timeout_count++;
        end
    endtask

    // one frame window from the current edge
    task automatic count_frame(output int de_cnt, output int hs_cnt, output int vs_cnt,
                               output int intr_cnt, output int hb_cnt, output int vb_cnt);
        int   n;
        logic hs_prev;
        de_cnt   = 0;
        hs_cnt   = 0;
        vs_cnt   = 0;
        intr_cnt = 0;
        hb_cnt   = 0;
        vb_cnt   = 0;
        hs_prev  = 1'b0;
        for (n = 0; n < TOTAL_WIDTH * TOTAL_HEIGHT; n++) begin
            de_cnt += dv_de_o;
            if (hsync_o && !hs_prev) begin
                hs_cnt++;
            end
            hs_prev = hsync_o;
            vs_cnt   += vsync_o;
            intr_cnt += video_intr_o;
            hb_cnt   += h_blank_o;
            vb_cnt   += v_blank_o;
            check_value(dv_de_o, !h_blank_o && !v_blank_o, "dv_de against blanking");
            @(posedge clk);
        end
    endtask

    task automatic check_frame(input pf_cfg_t cfg);
        set_config(cfg);
        wait_vsync_rise();                          // new start address loads at frame end
        checked_count = 0;
        check_en <= 1'b1;
        wait_vsync_rise();
        check_en <= 1'b0;
        check_value(checked_count, VISIBLE_WIDTH * VISIBLE_HEIGHT, "pixels compared in frame");
    endtask

    // one cycle read latency
    always @(posedge clk) begin
        if (vram_o.sel) begin
            vram_data_i <= vram_word(vram_o.addr);
        end
    end

    always @(posedge clk) begin
        if (reset_i || vsync_o) begin
            pix_n <= 0;
        end else if (dv_de_o) begin
            if (check_en) begin
                check_value(color_index_o,
                            ref_pixel(pix_n % VISIBLE_WIDTH, pix_n / VISIBLE_WIDTH, exp_cfg),
                            $sformatf("pixel x=%0d y=%0d", pix_n % VISIBLE_WIDTH,
                                      pix_n / VISIBLE_WIDTH));
                checked_count++;
            end
            pix_n <= pix_n + 1;
        end
    end

    initial begin
        int                  de_cnt;
        int                  hs_cnt;
        int                  vs_cnt;
        int                  intr_cnt;
        int                  hb_cnt;
        int                  vb_cnt;
        int                  i;
        logic [XR_NUM_W-1:0] num;
        word_t               value;
        word_t               rd;
        pf_cfg_t             cfg;
        clk            = 1'b0;
        reset_i        = 1'b1;
        xr_wr_i        = 1'b0;
        xr_num_i       = '0;
        xr_data_i      = '0;
        vram_data_i    = '0;
        check_en       = 1'b0;
        exp_cfg        = '0;
        rng            = 32'h6698;
        mismatch_count = 0;
        timeout_count  = 0;
        checked_count  = 0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        check_value({hsync_o, vsync_o, dv_de_o, video_intr_o, vram_o.sel}, '0,
                    "control outputs after reset");
        check_value(color_index_o, '0, "color index after reset");

        read_reg(XR_VID_CTRL, rd);
        check_value(rd, word_t'(RESET_BORDER), "VID_CTRL reset value");
        read_reg(XR_VID_LEFT, rd);
        check_value(rd, '0, "VID_LEFT reset value");
        read_reg(XR_VID_RIGHT, rd);
        check_value(rd, word_t'(VISIBLE_WIDTH), "VID_RIGHT reset value");
        read_reg(XR_PA_GFX_CTRL, rd);
        check_value(rd, 16'h0080, "PA_GFX_CTRL reset value");      // blanked
        read_reg(XR_PA_DISP_ADDR, rd);
        check_value(rd, '0, "PA_DISP_ADDR reset value");
        read_reg(XR_PA_LINE_LEN, rd);
        check_value(rd, RESET_LINE_LEN, "PA_LINE_LEN reset value");
        read_reg(XR_SCANLINE, rd);
        check_value(rd < TOTAL_HEIGHT, 1, "SCANLINE below total height");

        for (i = 0; i < 32; i++) begin
            num   = XR_NUM_W'(i);
            rng   = xorshift32(rng);
            value = rng[15:0];
            if ((num == XR_VID_LEFT) || (num == XR_VID_RIGHT)) begin
                value = word_t'(rng % (VISIBLE_WIDTH + 1));       // legal column range
            end
            if (num != XR_SCANLINE) begin
                write_reg(num, value);
                read_reg(num, rd);
                if (num <= XR_PA_LINE_LEN) begin
                    check_value(rd, readback_of(num, value), $sformatf("readback of reg %0d", i));
                end else begin
                    check_value(rd, '0, $sformatf("unused reg %0d", i));
                end
            end
        end

        wait_vsync_rise();
        count_frame(de_cnt, hs_cnt, vs_cnt, intr_cnt, hb_cnt, vb_cnt);
        check_value(de_cnt, VISIBLE_WIDTH * VISIBLE_HEIGHT, "dv_de cycles per frame");
        check_value(hs_cnt, TOTAL_HEIGHT, "hsync pulses per frame");
        check_value(vs_cnt, TOTAL_WIDTH, "vsync cycles per frame");
        check_value(hb_cnt, OFFSCREEN_WIDTH * TOTAL_HEIGHT, "h_blank cycles per frame");
        check_value(vb_cnt, (TOTAL_HEIGHT - VISIBLE_HEIGHT) * TOTAL_WIDTH,
                    "v_blank cycles per frame");
        for (i = 0; i < 3; i++) begin
            count_frame(de_cnt, hs_cnt, vs_cnt, intr_cnt, hb_cnt, vb_cnt);
            check_value(intr_cnt, 1, $sformatf("interrupt cycles in frame %0d", i));
        end

        rng              = xorshift32(rng);
        cfg.border_color = rng[7:0];
        cfg.colorbase    = rng[15:8];
        cfg.vid_left     = hres_t'(rng[19:16]);
        cfg.start_addr   = rng[31:16];
        rng              = xorshift32(rng);
        cfg.vid_right    = hres_t'(VISIBLE_WIDTH / 2 + rng % (VISIBLE_WIDTH / 2 + 1));
        cfg.line_len     = rng[31:16];
        cfg.blank        = 1'b0;
        check_frame(cfg);

        rng              = xorshift32(rng);
        cfg.border_color = rng[7:0];
        cfg.blank        = 1'b1;                    // border over whole lines
        check_frame(cfg);

        $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
        if ((mismatch_count == 0) && (timeout_count == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/video_pkg.sv
design/video_timing.sv
design/video_regs.sv
design/video_playfield.sv
design/video_gen.sv
testbench/video_gen_tb.sv
